// File: verification/mont_golden.txt
# Columns: a b m expected, all 64-bit hex
# expected = a * b * 2^-64 mod m
0000000000000003 0000000000000004 0000000000000005 0000000000000002
000000000000000b 000000000000000d 0000000000000011 0000000000000007
0000000000000100 00000000000000ff 0000000000000101 0000000000000002
0000000000010000 0000000000010000 0000000000010001 0000000000000001
0000000012345678 0000000000000100 0000000100000001 00000000345677ee
0000000000000002 3000000000000000 5555555555555555 0aaaaaaaaaaaaaab
5555555555555554 5555555555555554 5555555555555555 0000000000000001
0000000000000010 0111111111111111 1111111111111111 1111111111111110
0000000000000002 0000000000000002 0000000000000003 0000000000000001
000000000000000e 000000000000000d 000000000000000f 0000000000000002
0000000000000080 0000000000000004 00000000000000ff 0000000000000002
0000000000001234 0000000000000010 000000000000ffff 0000000000002341
0000000080000000 0000000000000004 00000000ffffffff 0000000000000002
fffffffffffffffe fffffffffffffffe ffffffffffffffff 0000000000000001
0123456789abcdef 0000000000000010 ffffffffffffffff 123456789abcdef0
8000000000000000 0000000000000003 ffffffffffffffff 8000000000000001
0000000000000000 0000000000001234 5555555555555555 0000000000000000
0000000000000003 1111111111111111 3333333333333333 0000000000000000
ffffffff00000000 0000000100000000 ffffffffffffffff 00000000ffffffff
0000000100000000 0000000000000002 0000000100000001 00000000ffffffff

// File: filelist.f
src/mont_arith_pkg.sv
src/mont_ctrl_pkg.sv
src/limb_adder.sv
src/operand_select.sv
src/accumulator.sv
src/mont_sequencer.sv
src/montgomery_top.sv
verification/montgomery_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= montgomery_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL TESTS PASSED
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/montgomery_tb.sv
`timescale 1ns/10ps

module montgomery_tb;

    localparam int          HALF_PERIOD    = 4;
    localparam int          RESET_CYCLES   = 8;
    localparam int          CYCLES_PER_VEC = 100;
    localparam int          IDLE_CHECKS    = 4;
    localparam int          BUSY_VEC       = 5;
    localparam int          BUSY_DELAY     = 6;
    localparam int          BUSY_WATCH     = 80;
    localparam logic [31:0] SEED           = 32'hb339_9c41;
    localparam string       GOLDEN_FILE    = "verification/mont_golden.txt";

    logic                  clk;
    logic                  resetn;
    logic                  start;
    mont_arith_pkg::opnd_t in_a;
    mont_arith_pkg::opnd_t in_b;
    mont_arith_pkg::opnd_t in_m;
    mont_arith_pkg::opnd_t result;
    logic                  done;

    mont_arith_pkg::opnd_t vec_a[$];
    mont_arith_pkg::opnd_t vec_b[$];
    mont_arith_pkg::opnd_t vec_m[$];
    mont_arith_pkg::opnd_t vec_exp[$];

    int errors;
    int checks;
    int cycles;
    int cycle_limit;

    montgomery_top DUT (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .in_a   (in_a),
        .in_b   (in_b),
        .in_m   (in_m),
        .result (result),
        .done   (done)
    );

    always #(HALF_PERIOD) clk = ~clk;

    // Watchdog limit is set once the vectors are known
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Summary: %0d checks, %0d errors", checks, errors);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: got 0x%h, expected 0x%h at %0t",
                     name, actual, expected, $time);
        end
    endtask

    // Lines starting with # are comments
    task automatic load_vectors();
        int                    fd;
        int                    n;
        string                 line;
        mont_arith_pkg::opnd_t a;
        mont_arith_pkg::opnd_t b;
        mont_arith_pkg::opnd_t m;
        mont_arith_pkg::opnd_t e;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the golden vector file %s", GOLDEN_FILE);
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h", a, b, m, e);
                if (n == 4) begin
                    vec_a.push_back(a);
                    vec_b.push_back(b);
                    vec_m.push_back(m);
                    vec_exp.push_back(e);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic launch(input int idx);
        @(posedge clk);
        in_a  <= vec_a[idx];
        in_b  <= vec_b[idx];
        in_m  <= vec_m[idx];
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // Second start with other operands while the DUT is busy
    task automatic busy_start(input int idx);
        repeat (BUSY_DELAY) @(posedge clk);
        in_a  <= ~vec_a[idx];
        in_b  <= ~vec_b[idx];
        in_m  <= vec_m[idx] + 64'd2;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done();
        @(negedge clk);
        while (!done) begin
            @(negedge clk);
        end
    endtask

    // Result must hold and no further done may appear
    task automatic hold_result(input mont_arith_pkg::opnd_t expected, input int n);
        repeat (n) begin
            @(negedge clk);
            check_value("done", 64'(done), 64'h0);
            check_value("result", result, expected);
        end
    endtask

    initial begin
        int gap;
        clk         = 1'b0;
        resetn      = 1'b0;
        start       = 1'b0;
        in_a        = '0;
        in_b        = '0;
        in_m        = '0;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        cycle_limit = 0;
        void'($urandom(SEED));

        load_vectors();
        if (vec_a.size() == 0) begin
            $display("No test vectors were loaded, nothing was run");
            errors++;
        end else begin
            cycle_limit = vec_a.size() * CYCLES_PER_VEC + RESET_CYCLES;
            repeat (RESET_CYCLES) @(posedge clk);
            resetn <= 1'b1;

            // Quiet outputs before the first start
            repeat (IDLE_CHECKS) begin
                @(negedge clk);
                check_value("done", 64'(done), 64'h0);
                check_value("result", result, 64'h0);
            end

            foreach (vec_a[i]) begin
                launch(i);
                if (i == BUSY_VEC) begin
                    busy_start(i);
                end
                wait_done();
                check_value("result", result, vec_exp[i]);
                // First gap is zero, so the next start follows done directly
                if (i == BUSY_VEC) begin
                    gap = BUSY_WATCH;
                end else if (i == 0) begin
                    gap = 0;
                end else begin
                    gap = int'($urandom % 4);
                end
                hold_result(vec_exp[i], gap);
            end
        end

        $display("Summary: %0d vectors, %0d checks, %0d errors",
                 vec_a.size(), checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: src/montgomery_top.sv
`timescale 1ns/10ps

module montgomery_top (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  start,
    input  mont_arith_pkg::opnd_t in_a,
    input  mont_arith_pkg::opnd_t in_b,
    input  mont_arith_pkg::opnd_t in_m,
    output mont_arith_pkg::opnd_t result,
    output logic                  done
);

    mont_ctrl_pkg::ctrl_word_t        ctrl;
    mont_arith_pkg::acc_t             opnd_a;
    mont_arith_pkg::acc_t             opnd_b;
    wire mont_arith_pkg::acc_t        sum;
    wire [mont_arith_pkg::LIMBS:0]    carry;
    logic [1:0]                       acc_digit;
    logic                             acc_sign;

    mont_sequencer u_sequencer (
        .clk      (clk),
        .resetn   (resetn),
        .start    (start),
        .acc_sign (acc_sign),
        .ctrl     (ctrl),
        .done     (done)
    );

    operand_select u_operand_select (
        .clk       (clk),
        .resetn    (resetn),
        .ctrl      (ctrl),
        .in_a      (in_a),
        .in_b      (in_b),
        .in_m      (in_m),
        .acc_digit (acc_digit),
        .sum       (sum),
        .opnd_b    (opnd_b)
    );

    accumulator u_accumulator (
        .clk       (clk),
        .resetn    (resetn),
        .ctrl      (ctrl),
        .sum       (sum),
        .opnd_a    (opnd_a),
        .acc_digit (acc_digit),
        .acc_sign  (acc_sign),
        .result    (result)
    );

    // Carry ripples upward from slice 0
    assign carry[0] = ctrl.subtract;

    for (genvar i = 0; i < mont_arith_pkg::LIMBS; i++) begin : g_limb
        limb_adder u_limb (
            .a        (opnd_a[i*mont_arith_pkg::LIMB_W +: mont_arith_pkg::LIMB_W]),
            .b        (opnd_b[i*mont_arith_pkg::LIMB_W +: mont_arith_pkg::LIMB_W]),
            .subtract (ctrl.subtract),
            .cin      (carry[i]),
            .sum      (sum[i*mont_arith_pkg::LIMB_W +: mont_arith_pkg::LIMB_W]),
            .cout     (carry[i+1])
        );
    end

endmodule

// File: src/mont_sequencer.sv
`timescale 1ns/10ps

module mont_sequencer (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      start,
    input  logic                      acc_sign,
    output mont_ctrl_pkg::ctrl_word_t ctrl,
    output logic                      done
);

    mont_ctrl_pkg::state_e             state_q;
    mont_ctrl_pkg::state_e             state_d;
    logic [mont_arith_pkg::CNT_W-1:0]  cnt_q;
    logic                              pre_last;
    logic                              iter_last;
    logic                              first_add;
    logic                              done_q;

    assign pre_last  = (cnt_q == mont_arith_pkg::CNT_W'(mont_ctrl_pkg::PRE_LAST));
    assign iter_last = (cnt_q == mont_arith_pkg::CNT_W'(mont_arith_pkg::ITER - 1));
    assign first_add = (cnt_q == '0);

    always_comb begin
        ctrl    = mont_ctrl_pkg::CTRL_NOP;
        state_d = state_q;
        case (state_q)
            mont_ctrl_pkg::IDLE: begin
                if (start) begin
                    ctrl.load = 1'b1;
                    state_d   = mont_ctrl_pkg::PRE_B;
                end
            end
            // x, 2x, then 3x goes to the multiple register only
            mont_ctrl_pkg::PRE_B: begin
                ctrl.sel           = mont_ctrl_pkg::B;
                ctrl.acc_from_zero = first_add;
                ctrl.acc_write     = !pre_last;
                ctrl.cap_b3        = pre_last;
                if (pre_last) begin
                    state_d = mont_ctrl_pkg::PRE_M;
                end
            end
            mont_ctrl_pkg::PRE_M: begin
                ctrl.sel           = mont_ctrl_pkg::M;
                ctrl.acc_from_zero = first_add;
                ctrl.acc_write     = !pre_last;
                ctrl.cap_m3        = pre_last;
                if (pre_last) begin
                    state_d = mont_ctrl_pkg::ADD_B;
                end
            end
            // Accumulator still holds 2M on the first iteration
            mont_ctrl_pkg::ADD_B: begin
                ctrl.sel           = mont_ctrl_pkg::B_DIGIT;
                ctrl.acc_from_zero = first_add;
                ctrl.acc_write     = 1'b1;
                state_d            = mont_ctrl_pkg::ADD_M;
            end
            mont_ctrl_pkg::ADD_M: begin
                ctrl.sel       = mont_ctrl_pkg::M_DIGIT;
                ctrl.acc_write = 1'b1;
                ctrl.acc_shift = 1'b1;
                ctrl.a_shift   = 1'b1;
                state_d        = iter_last ? mont_ctrl_pkg::SUB_M : mont_ctrl_pkg::ADD_B;
            end
            // Stop writing once the held value went negative
            mont_ctrl_pkg::SUB_M: begin
                ctrl.sel       = mont_ctrl_pkg::M;
                ctrl.subtract  = 1'b1;
                ctrl.acc_write = !acc_sign;
                if (acc_sign) begin
                    state_d = mont_ctrl_pkg::ADD_BACK;
                end
            end
            mont_ctrl_pkg::ADD_BACK: begin
                ctrl.sel       = mont_ctrl_pkg::M;
                ctrl.acc_write = 1'b1;
                state_d        = mont_ctrl_pkg::DONE;
            end
            default: begin
                state_d = mont_ctrl_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= mont_ctrl_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Additions per precompute phase, iterations in the main loop
    always_ff @(posedge clk) begin
        if (!resetn) begin
            cnt_q <= '0;
        end else if (state_q == mont_ctrl_pkg::PRE_B || state_q == mont_ctrl_pkg::PRE_M) begin
            cnt_q <= pre_last ? '0 : cnt_q + 1'b1;
        end else if (state_q == mont_ctrl_pkg::ADD_M) begin
            cnt_q <= iter_last ? '0 : cnt_q + 1'b1;
        end
    end

    // High for the single DONE cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            done_q <= 1'b0;
        end else begin
            done_q <= (state_q == mont_ctrl_pkg::ADD_BACK);
        end
    end

    assign done = done_q;

endmodule

// File: src/accumulator.sv
`timescale 1ns/10ps

module accumulator (
    input  logic                      clk,
    input  logic                      resetn,
    input  mont_ctrl_pkg::ctrl_word_t ctrl,
    input  mont_arith_pkg::acc_t      sum,
    output mont_arith_pkg::acc_t      opnd_a,
    output logic [1:0]                acc_digit,
    output logic                      acc_sign,
    output mont_arith_pkg::opnd_t     result
);

    mont_arith_pkg::acc_word_u acc_q;
    mont_arith_pkg::acc_word_u sum_u;
    mont_arith_pkg::acc_t      sum_shifted;

    assign sum_u.word = sum;

    // Divide by four since the low digit is zero after the M multiple is added
    assign sum_shifted = {2'b00, sum_u.f.sign, sum_u.f.body};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            acc_q.word <= '0;
        end else if (ctrl.load) begin
            acc_q.word <= '0;
        end else if (ctrl.acc_write) begin
            acc_q.word <= ctrl.acc_shift ? sum_shifted : sum;
        end
    end

    assign opnd_a = ctrl.acc_from_zero ? '0 : acc_q.word;

    assign acc_digit = acc_q.f.digit;
    assign acc_sign  = acc_q.f.sign;

    // Holds the reduced value after the add-back step
    assign result = acc_q.word[mont_arith_pkg::OPND_W-1:0];

endmodule

// File: src/operand_select.sv
`timescale 1ns/10ps

module operand_select (
    input  logic                     clk,
    input  logic                     resetn,
    input  mont_ctrl_pkg::ctrl_word_t ctrl,
    input  mont_arith_pkg::opnd_t    in_a,
    input  mont_arith_pkg::opnd_t    in_b,
    input  mont_arith_pkg::opnd_t    in_m,
    input  logic [1:0]               acc_digit,
    input  mont_arith_pkg::acc_t     sum,
    output mont_arith_pkg::acc_t     opnd_b
);

    mont_arith_pkg::opnd_t a_q;
    mont_arith_pkg::opnd_t b_q;
    mont_arith_pkg::opnd_t m_q;
    mont_arith_pkg::acc_t  b3_q;
    mont_arith_pkg::acc_t  m3_q;
    mont_arith_pkg::acc_t  b_mult;
    mont_arith_pkg::acc_t  m_mult;
    logic [1:0]            q_digit;

    // Operand registers with a consumed two bits per iteration
    always_ff @(posedge clk) begin
        if (!resetn) begin
            a_q <= '0;
            b_q <= '0;
            m_q <= '0;
        end else if (ctrl.load) begin
            a_q <= in_a;
            b_q <= in_b;
            m_q <= in_m;
        end else if (ctrl.a_shift) begin
            a_q <= a_q >> 2;
        end
    end

    // 3B and 3M come from the shared adder
    always_ff @(posedge clk) begin
        if (ctrl.cap_b3) begin
            b3_q <= sum;
        end
        if (ctrl.cap_m3) begin
            m3_q <= sum;
        end
    end

    always_comb begin
        case (a_q[1:0])
            2'd1:    b_mult = mont_arith_pkg::acc_t'(b_q);
            2'd2:    b_mult = mont_arith_pkg::acc_t'({b_q, 1'b0});
            2'd3:    b_mult = b3_q;
            default: b_mult = '0;
        endcase
    end

    // q = -digit / m mod 4 gives -digit for m = 1 mod 4 and digit for m = 3 mod 4
    assign q_digit = m_q[1] ? acc_digit : 2'd0 - acc_digit;

    always_comb begin
        case (q_digit)
            2'd1:    m_mult = mont_arith_pkg::acc_t'(m_q);
            2'd2:    m_mult = mont_arith_pkg::acc_t'({m_q, 1'b0});
            2'd3:    m_mult = m3_q;
            default: m_mult = '0;
        endcase
    end

    always_comb begin
        case (ctrl.sel)
            mont_ctrl_pkg::B:       opnd_b = mont_arith_pkg::acc_t'(b_q);
            mont_ctrl_pkg::M:       opnd_b = mont_arith_pkg::acc_t'(m_q);
            mont_ctrl_pkg::B_DIGIT: opnd_b = b_mult;
            mont_ctrl_pkg::M_DIGIT: opnd_b = m_mult;
            default:                opnd_b = '0;
        endcase
    end

endmodule

// File: src/limb_adder.sv
`timescale 1ns/10ps

module limb_adder (
    input  logic [mont_arith_pkg::LIMB_W-1:0] a,
    input  logic [mont_arith_pkg::LIMB_W-1:0] b,
    input  logic                              subtract,
    input  logic                              cin,
    output logic [mont_arith_pkg::LIMB_W-1:0] sum,
    output logic                              cout
);

    logic [mont_arith_pkg::LIMB_W-1:0] b_eff;
    logic [mont_arith_pkg::LIMB_W:0]   total;

    // Two's complement subtract with the +1 arriving as cin of slice 0
    assign b_eff = subtract ? ~b : b;

    assign total = {1'b0, a} + {1'b0, b_eff} + {{mont_arith_pkg::LIMB_W{1'b0}}, cin};

    assign sum  = total[mont_arith_pkg::LIMB_W-1:0];
    assign cout = total[mont_arith_pkg::LIMB_W];

endmodule

// File: src/mont_ctrl_pkg.sv
package mont_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        PRE_B,
        PRE_M,
        ADD_B,
        ADD_M,
        SUB_M,
        ADD_BACK,
        DONE
    } state_e;

    // What operand_select drives onto the adder B input
    typedef enum logic [2:0] {
        ZERO,
        B,
        M,
        B_DIGIT,
        M_DIGIT
    } opnd_sel_e;

    typedef struct packed {
        logic      load;
        opnd_sel_e sel;
        logic      subtract;
        logic      acc_from_zero;
        logic      acc_write;
        logic      acc_shift;
        logic      cap_b3;
        logic      cap_m3;
        logic      a_shift;
    } ctrl_word_t;

    // No operation in idle and as the default
    localparam ctrl_word_t CTRL_NOP = '0;

    // Count of the last addition in each precompute phase (x, 2x, 3x)
    localparam int PRE_LAST = 2;

endpackage

// File: src/mont_arith_pkg.sv
package mont_arith_pkg;

    // Operand and datapath widths
    localparam int OPND_W = 64;
    localparam int ACC_W  = OPND_W + 4;

    // Ripple adder is split into equal slices
    localparam int LIMB_W = 17;
    localparam int LIMBS  = ACC_W / LIMB_W;

    // One radix-4 digit of a per iteration
    localparam int ITER  = OPND_W / 2;
    localparam int CNT_W = $clog2(ITER + 1);

    typedef logic [OPND_W-1:0] opnd_t;
    typedef logic [ACC_W-1:0]  acc_t;

    // Field view of the accumulator word
    // digit picks the M multiple, sign ends the final subtract loop
    typedef struct packed {
        logic             sign;
        logic [ACC_W-4:0] body;
        logic [1:0]       digit;
    } acc_fields_t;

    typedef union packed {
        acc_t        word;
        acc_fields_t f;
    } acc_word_u;

endpackage
